/* hbm_ctrl_pkg.sv */
package hbm_ctrl_pkg;

    // ----------------------------------------
    // Widths and limits
    // ----------------------------------------
    localparam int REG_ADDR_WID       = 12;
    localparam int REG_DATA_WID       = 32;
    localparam int APB_ADDR_WID       = 10;
    localparam int MEM_ADDR_WID       = 24;
    localparam int MEM_DATA_WID       = 64;
    localparam int MEM_TIMEOUT_CYCLES = 64;
    localparam int MEM_TIMEOUT_WID    = $clog2(MEM_TIMEOUT_CYCLES);

    localparam logic [REG_DATA_WID-1:0] UNMAPPED_RDATA = 32'hDEAD_0BAD;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    // Stack register block
    localparam logic [REG_ADDR_WID-1:0] REG_CONTROL      = 12'h000;
    localparam logic [REG_ADDR_WID-1:0] REG_STATUS       = 12'h004;
    localparam logic [REG_ADDR_WID-1:0] REG_DRAM_STATUS  = 12'h008;

    // Memory proxy
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_ADDR     = 12'h800;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_WDATA_LO = 12'h804;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_WDATA_HI = 12'h808;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_COMMAND  = 12'h80C;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_STATUS   = 12'h810;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_RDATA_LO = 12'h814;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_RDATA_HI = 12'h818;

    // ----------------------------------------
    // Enums
    // ----------------------------------------
    // Address bits 11:10
    typedef enum logic [1:0] {
        REGION_STACK = 2'd0,
        REGION_APB   = 2'd1,
        REGION_MEM   = 2'd2,
        REGION_NONE  = 2'd3
    } region_t;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } mem_cmd_t;

    typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

    typedef enum logic [1:0] {MEM_IDLE, MEM_REQ, MEM_DONE} mem_state_t;

endpackage

/* reg_bus_if.sv */
`timescale 1ns/1ns

interface reg_bus_if;
    import hbm_ctrl_pkg::*;

    // One-cycle request, answered by exactly one ack pulse
    logic                    req;
    logic                    wr;
    logic [REG_ADDR_WID-1:0] addr;
    logic [REG_DATA_WID-1:0] wdata;
    logic [REG_DATA_WID-1:0] rdata;
    logic                    ack;

    modport host (
        output req, wr, addr, wdata,
        input  rdata, ack
    );

    modport target (
        input  req, wr, addr, wdata,
        output rdata, ack
    );

endinterface

/* hbm_reg_decoder.sv */
`timescale 1ns/1ns

module hbm_reg_decoder (
    input  logic      clk,
    input  logic      i_rst,
    reg_bus_if.target host_bus,
    reg_bus_if.host   stack_bus,
    reg_bus_if.host   apb_bus,
    reg_bus_if.host   mem_bus
);
    import hbm_ctrl_pkg::*;

    region_t region;
    logic    none_ack;

    assign region = region_t'(host_bus.addr[11:10]);

    // ----------------------------------------
    // Request steering
    // ----------------------------------------
    assign stack_bus.req   = host_bus.req && (region == REGION_STACK);
    assign apb_bus.req     = host_bus.req && (region == REGION_APB);
    assign mem_bus.req     = host_bus.req && (region == REGION_MEM);

    // Access fields go to every target, only req selects
    assign stack_bus.wr    = host_bus.wr;
    assign stack_bus.addr  = host_bus.addr;
    assign stack_bus.wdata = host_bus.wdata;
    assign apb_bus.wr      = host_bus.wr;
    assign apb_bus.addr    = host_bus.addr;
    assign apb_bus.wdata   = host_bus.wdata;
    assign mem_bus.wr      = host_bus.wr;
    assign mem_bus.addr    = host_bus.addr;
    assign mem_bus.wdata   = host_bus.wdata;

    // Unmapped region answers on its own, writes dropped
    always_ff @(posedge clk) begin
        if (i_rst) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= host_bus.req && (region == REGION_NONE);
        end
    end

    // ----------------------------------------
    // Response merge
    // ----------------------------------------
    assign host_bus.ack = stack_bus.ack | apb_bus.ack | mem_bus.ack | none_ack;

    // Each source is masked by its own ack
    assign host_bus.rdata = ({REG_DATA_WID{stack_bus.ack}} & stack_bus.rdata)
                          | ({REG_DATA_WID{apb_bus.ack}}   & apb_bus.rdata)
                          | ({REG_DATA_WID{mem_bus.ack}}   & mem_bus.rdata)
                          | ({REG_DATA_WID{none_ack}}      & UNMAPPED_RDATA);

endmodule

/* hbm_stack_regs.sv */
`timescale 1ns/1ns

module hbm_stack_regs (
    input  logic       clk,
    input  logic       i_rst,
    reg_bus_if.target  bus,
    input  logic       i_apb_complete,
    input  logic       i_dram_cattrip,
    input  logic [6:0] i_dram_temp,
    output logic       o_init_done,
    output logic       o_local_rst
);
    import hbm_ctrl_pkg::*;

    logic       soft_rst;
    logic [8:0] status_async;
    logic [8:0] status_meta;
    logic [8:0] status_sync;
    logic       init_done;
    logic       cattrip;
    logic [6:0] temp;

    // ----------------------------------------
    // Control and local reset
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            soft_rst <= 1'b0;
        end else if (bus.req && bus.wr && (bus.addr == REG_CONTROL)) begin
            soft_rst <= bus.wdata[0];
        end
    end

    // Held until a cycle after both sources are low
    always_ff @(posedge clk) begin
        o_local_rst <= i_rst || soft_rst;
    end

    // ----------------------------------------
    // Status synchronizer
    // ----------------------------------------
    assign status_async = {i_apb_complete, i_dram_cattrip, i_dram_temp};

    always_ff @(posedge clk) begin
        if (i_rst) begin
            status_meta <= '0;
            status_sync <= '0;
        end else begin
            status_meta <= status_async;
            status_sync <= status_meta;
        end
    end

    assign init_done   = status_sync[8];
    assign cattrip     = status_sync[7];
    assign temp        = status_sync[6:0];
    assign o_init_done = init_done;

    // ----------------------------------------
    // Register read port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req;
        end
    end

    // Status offsets are read only
    always_ff @(posedge clk) begin
        case (bus.addr)
            REG_CONTROL:     bus.rdata <= REG_DATA_WID'(soft_rst);
            REG_STATUS:      bus.rdata <= REG_DATA_WID'({init_done, o_local_rst});
            REG_DRAM_STATUS: bus.rdata <= REG_DATA_WID'({cattrip, 1'b0, temp});
            default:         bus.rdata <= '0;
        endcase
    end

endmodule

/* hbm_apb_bridge.sv */
`timescale 1ns/1ns

module hbm_apb_bridge (
    input  logic                                  clk,
    input  logic                                  i_rst,
    reg_bus_if.target                             bus,
    output logic                                  o_apb_psel,
    output logic                                  o_apb_penable,
    output logic                                  o_apb_pwrite,
    output logic [hbm_ctrl_pkg::APB_ADDR_WID-1:0] o_apb_paddr,
    output logic [hbm_ctrl_pkg::REG_DATA_WID-1:0] o_apb_pwdata,
    input  logic [hbm_ctrl_pkg::REG_DATA_WID-1:0] i_apb_prdata,
    input  logic                                  i_apb_pready
);
    import hbm_ctrl_pkg::*;

    apb_state_t state;

    // ----------------------------------------
    // APB phase FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= APB_IDLE;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            case (state)
                APB_IDLE: begin
                    if (bus.req) begin
                        state <= APB_SETUP;
                    end
                end
                // Setup lasts exactly one cycle
                APB_SETUP: state <= APB_ACCESS;
                APB_ACCESS: begin
                    if (i_apb_pready) begin
                        state   <= APB_IDLE;
                        bus.ack <= 1'b1;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // Request fields held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == APB_IDLE && bus.req) begin
            o_apb_pwrite <= bus.wr;
            o_apb_paddr  <= bus.addr[APB_ADDR_WID-1:0];
            o_apb_pwdata <= bus.wdata;
        end
    end

    // Completer data, returned with the ack
    always_ff @(posedge clk) begin
        if (state == APB_ACCESS && i_apb_pready) begin
            bus.rdata <= i_apb_prdata;
        end
    end

    assign o_apb_psel    = (state != APB_IDLE);
    assign o_apb_penable = (state == APB_ACCESS);

endmodule

/* hbm_mem_proxy.sv */
`timescale 1ns/1ns

module hbm_mem_proxy (
    input  logic                                  clk,
    input  logic                                  i_local_rst,
    reg_bus_if.target                             bus,
    output logic                                  o_mem_req,
    output logic                                  o_mem_wr,
    output logic [hbm_ctrl_pkg::MEM_ADDR_WID-1:0] o_mem_addr,
    output logic [hbm_ctrl_pkg::MEM_DATA_WID-1:0] o_mem_wdata,
    input  logic                                  i_mem_ack,
    input  logic [hbm_ctrl_pkg::MEM_DATA_WID-1:0] i_mem_rdata
);
    import hbm_ctrl_pkg::*;

    mem_state_t                 state;
    mem_cmd_t                   cmd;
    mem_cmd_t                   cmd_in;
    logic                       busy;
    logic                       done;
    logic                       timeout;
    logic [MEM_TIMEOUT_WID-1:0] wait_cnt;
    logic [MEM_ADDR_WID-1:0]    mem_addr;
    logic [REG_DATA_WID-1:0]    wdata_lo;
    logic [REG_DATA_WID-1:0]    wdata_hi;
    logic [MEM_DATA_WID-1:0]    rdata;
    logic                       wr_en;
    logic                       cmd_start;

    assign busy   = (state != MEM_IDLE);
    assign wr_en  = bus.req && bus.wr;
    assign cmd_in = mem_cmd_t'(bus.wdata[1:0]);

    // Only a valid opcode while idle starts a transaction
    assign cmd_start = wr_en && !busy && (bus.addr == REG_MEM_COMMAND)
                     && ((cmd_in == CMD_WRITE) || (cmd_in == CMD_READ));

    // ----------------------------------------
    // Staging registers
    // ----------------------------------------
    // Frozen while busy so the memory port stays stable
    always_ff @(posedge clk) begin
        if (wr_en && !busy) begin
            case (bus.addr)
                REG_MEM_ADDR:     mem_addr <= bus.wdata[MEM_ADDR_WID-1:0];
                REG_MEM_WDATA_LO: wdata_lo <= bus.wdata;
                REG_MEM_WDATA_HI: wdata_hi <= bus.wdata;
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Transaction FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_local_rst) begin
            state    <= MEM_IDLE;
            cmd      <= CMD_NONE;
            done     <= 1'b0;
            timeout  <= 1'b0;
            wait_cnt <= '0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (cmd_start) begin
                        state    <= MEM_REQ;
                        cmd      <= cmd_in;
                        done     <= 1'b0;
                        timeout  <= 1'b0;
                        wait_cnt <= '0;
                    end
                end
                MEM_REQ: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (i_mem_ack) begin
                        done  <= 1'b1;
                        state <= MEM_DONE;
                    end else if (wait_cnt == MEM_TIMEOUT_WID'(MEM_TIMEOUT_CYCLES - 1)) begin
                        timeout <= 1'b1;
                        state   <= MEM_DONE;
                    end
                end
                // Request already dropped, busy clears next cycle
                MEM_DONE: state <= MEM_IDLE;
                default:  state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MEM_REQ && i_mem_ack) begin
            rdata <= i_mem_rdata;
        end
    end

    assign o_mem_req   = (state == MEM_REQ);
    assign o_mem_wr    = (cmd == CMD_WRITE);
    assign o_mem_addr  = mem_addr;
    assign o_mem_wdata = {wdata_hi, wdata_lo};

    // ----------------------------------------
    // Register read port
    // ----------------------------------------
    // Stays responsive during local reset so status can be read back
    always_ff @(posedge clk) begin
        bus.ack <= bus.req;
        case (bus.addr)
            REG_MEM_ADDR:     bus.rdata <= REG_DATA_WID'(mem_addr);
            REG_MEM_WDATA_LO: bus.rdata <= wdata_lo;
            REG_MEM_WDATA_HI: bus.rdata <= wdata_hi;
            REG_MEM_COMMAND:  bus.rdata <= REG_DATA_WID'(cmd);
            REG_MEM_STATUS:   bus.rdata <= REG_DATA_WID'({timeout, done, busy});
            REG_MEM_RDATA_LO: bus.rdata <= rdata[REG_DATA_WID-1:0];
            REG_MEM_RDATA_HI: bus.rdata <= rdata[MEM_DATA_WID-1:REG_DATA_WID];
            default:          bus.rdata <= '0;
        endcase
    end

endmodule

/* hbm_stack_ctrl.sv */
`timescale 1ns/1ns

module hbm_stack_ctrl (
    input  logic                                  clk,
    input  logic                                  i_rst,

    // Host register port
    input  logic                                  i_reg_req,
    input  logic                                  i_reg_wr,
    input  logic [hbm_ctrl_pkg::REG_ADDR_WID-1:0] i_reg_addr,
    input  logic [hbm_ctrl_pkg::REG_DATA_WID-1:0] i_reg_wdata,
    output logic [hbm_ctrl_pkg::REG_DATA_WID-1:0] o_reg_rdata,
    output logic                                  o_reg_ack,

    // Channel configuration APB
    output logic                                  o_apb_psel,
    output logic                                  o_apb_penable,
    output logic                                  o_apb_pwrite,
    output logic [hbm_ctrl_pkg::APB_ADDR_WID-1:0] o_apb_paddr,
    output logic [hbm_ctrl_pkg::REG_DATA_WID-1:0] o_apb_pwdata,
    input  logic [hbm_ctrl_pkg::REG_DATA_WID-1:0] i_apb_prdata,
    input  logic                                  i_apb_pready,

    // Memory port
    output logic                                  o_mem_req,
    output logic                                  o_mem_wr,
    output logic [hbm_ctrl_pkg::MEM_ADDR_WID-1:0] o_mem_addr,
    output logic [hbm_ctrl_pkg::MEM_DATA_WID-1:0] o_mem_wdata,
    input  logic                                  i_mem_ack,
    input  logic [hbm_ctrl_pkg::MEM_DATA_WID-1:0] i_mem_rdata,

    // Asynchronous status
    input  logic                                  i_apb_complete,
    input  logic                                  i_dram_cattrip,
    input  logic [6:0]                            i_dram_temp,
    output logic                                  o_init_done
);

    logic local_rst;

    reg_bus_if host_bus ();
    reg_bus_if stack_bus ();
    reg_bus_if apb_bus ();
    reg_bus_if mem_bus ();

    assign host_bus.req   = i_reg_req;
    assign host_bus.wr    = i_reg_wr;
    assign host_bus.addr  = i_reg_addr;
    assign host_bus.wdata = i_reg_wdata;
    assign o_reg_rdata    = host_bus.rdata;
    assign o_reg_ack      = host_bus.ack;

    hbm_reg_decoder i_hbm_reg_decoder (
        .clk       ( clk ),
        .i_rst     ( i_rst ),
        .host_bus  ( host_bus ),
        .stack_bus ( stack_bus ),
        .apb_bus   ( apb_bus ),
        .mem_bus   ( mem_bus )
    );

    hbm_stack_regs i_hbm_stack_regs (
        .clk            ( clk ),
        .i_rst          ( i_rst ),
        .bus            ( stack_bus ),
        .i_apb_complete ( i_apb_complete ),
        .i_dram_cattrip ( i_dram_cattrip ),
        .i_dram_temp    ( i_dram_temp ),
        .o_init_done    ( o_init_done ),
        .o_local_rst    ( local_rst )
    );

    hbm_apb_bridge i_hbm_apb_bridge (
        .clk           ( clk ),
        .i_rst         ( i_rst ),
        .bus           ( apb_bus ),
        .o_apb_psel    ( o_apb_psel ),
        .o_apb_penable ( o_apb_penable ),
        .o_apb_pwrite  ( o_apb_pwrite ),
        .o_apb_paddr   ( o_apb_paddr ),
        .o_apb_pwdata  ( o_apb_pwdata ),
        .i_apb_prdata  ( i_apb_prdata ),
        .i_apb_pready  ( i_apb_pready )
    );

    // Memory proxy runs from the local reset
    hbm_mem_proxy i_hbm_mem_proxy (
        .clk         ( clk ),
        .i_local_rst ( local_rst ),
        .bus         ( mem_bus ),
        .o_mem_req   ( o_mem_req ),
        .o_mem_wr    ( o_mem_wr ),
        .o_mem_addr  ( o_mem_addr ),
        .o_mem_wdata ( o_mem_wdata ),
        .i_mem_ack   ( i_mem_ack ),
        .i_mem_rdata ( i_mem_rdata )
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

endmodule

/* tb_hbm_stack_ctrl.sv */
`timescale 1ns/1ns

module tb_hbm_stack_ctrl;
    import hbm_ctrl_pkg::*;

    localparam int ACK_LIMIT  = 50;
    localparam int POLL_LIMIT = 100;
    localparam int APB_DEPTH  = 16;

    logic                    clk;
    logic                    i_rst;
    logic                    i_reg_req;
    logic                    i_reg_wr;
    logic [REG_ADDR_WID-1:0] i_reg_addr;
    logic [REG_DATA_WID-1:0] i_reg_wdata;
    logic [REG_DATA_WID-1:0] o_reg_rdata;
    logic                    o_reg_ack;
    logic                    o_apb_psel;
    logic                    o_apb_penable;
    logic                    o_apb_pwrite;
    logic [APB_ADDR_WID-1:0] o_apb_paddr;
    logic [REG_DATA_WID-1:0] o_apb_pwdata;
    logic [REG_DATA_WID-1:0] i_apb_prdata = '0;
    logic                    i_apb_pready = 1'b0;
    logic                    o_mem_req;
    logic                    o_mem_wr;
    logic [MEM_ADDR_WID-1:0] o_mem_addr;
    logic [MEM_DATA_WID-1:0] o_mem_wdata;
    logic                    i_mem_ack    = 1'b0;
    logic [MEM_DATA_WID-1:0] i_mem_rdata  = '0;
    logic                    i_apb_complete;
    logic                    i_dram_cattrip;
    logic [6:0]              i_dram_temp;
    logic                    o_init_done;

    // APB slave model
    logic [REG_DATA_WID-1:0] apb_regs [APB_DEPTH];
    logic [APB_ADDR_WID-1:0] exp_paddr;
    logic                    exp_pwrite;
    logic [REG_DATA_WID-1:0] exp_pwdata;
    logic                    apb_prev_setup = 1'b0;
    logic                    apb_prev_enable = 1'b0;
    int                      apb_wait = 0;

    // Memory model
    logic [MEM_DATA_WID-1:0] mem_model [logic [MEM_ADDR_WID-1:0]];
    logic                    mem_never_ack;
    logic                    exp_mem_wr;
    logic                    mem_active = 1'b0;
    int                      mem_wait = 0;

    tb_clock_gen i_tb_clock_gen (
        .o_clk ( clk )
    );

    hbm_stack_ctrl i_hbm_stack_ctrl (
        .clk            ( clk ),
        .i_rst          ( i_rst ),
        .i_reg_req      ( i_reg_req ),
        .i_reg_wr       ( i_reg_wr ),
        .i_reg_addr     ( i_reg_addr ),
        .i_reg_wdata    ( i_reg_wdata ),
        .o_reg_rdata    ( o_reg_rdata ),
        .o_reg_ack      ( o_reg_ack ),
        .o_apb_psel     ( o_apb_psel ),
        .o_apb_penable  ( o_apb_penable ),
        .o_apb_pwrite   ( o_apb_pwrite ),
        .o_apb_paddr    ( o_apb_paddr ),
        .o_apb_pwdata   ( o_apb_pwdata ),
        .i_apb_prdata   ( i_apb_prdata ),
        .i_apb_pready   ( i_apb_pready ),
        .o_mem_req      ( o_mem_req ),
        .o_mem_wr       ( o_mem_wr ),
        .o_mem_addr     ( o_mem_addr ),
        .o_mem_wdata    ( o_mem_wdata ),
        .i_mem_ack      ( i_mem_ack ),
        .i_mem_rdata    ( i_mem_rdata ),
        .i_apb_complete ( i_apb_complete ),
        .i_dram_cattrip ( i_dram_cattrip ),
        .i_dram_temp    ( i_dram_temp ),
        .o_init_done    ( o_init_done )
    );

    // ----------------------------------------
    // Checking and host access
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s actual 0x%h expected 0x%h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // One request pulse and a wait for the ack
    task automatic reg_access(input logic wr, input logic [REG_ADDR_WID-1:0] addr,
                              input logic [REG_DATA_WID-1:0] wdata,
                              output logic [REG_DATA_WID-1:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        i_reg_req   <= 1'b1;
        i_reg_wr    <= wr;
        i_reg_addr  <= addr;
        i_reg_wdata <= wdata;
        @(posedge clk);
        i_reg_req <= 1'b0;
        @(negedge clk);
        while (!o_reg_ack) begin
            cycles++;
            if (cycles > ACK_LIMIT) begin
                fail_run($sformatf("No ack for register access at 0x%h", addr));
            end
            @(negedge clk);
        end
        rdata = o_reg_rdata;
    endtask

    task automatic reg_write(input logic [REG_ADDR_WID-1:0] addr,
                             input logic [REG_DATA_WID-1:0] data);
        logic [REG_DATA_WID-1:0] unused;
        reg_access(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input logic [REG_ADDR_WID-1:0] addr,
                            output logic [REG_DATA_WID-1:0] data);
        reg_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_mem_idle(output logic [REG_DATA_WID-1:0] status);
        int polls;
        polls = 0;
        reg_read(REG_MEM_STATUS, status);
        while (status[0]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_run("Memory proxy stayed busy");
            end
            reg_read(REG_MEM_STATUS, status);
        end
    endtask

    function automatic logic [MEM_DATA_WID-1:0] mem_read(input logic [MEM_ADDR_WID-1:0] addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return {addr, 8'h3C, ~addr, 8'h96};
    endfunction

    // ----------------------------------------
    // Bus models
    // ----------------------------------------
    always @(posedge clk) begin
        if (i_rst) begin
            i_apb_pready <= 1'b0;
            apb_prev_setup <= 1'b0;
            apb_prev_enable <= 1'b0;
            for (int i = 0; i < APB_DEPTH; i++) begin
                apb_regs[i] <= 32'hA900_0000 | 32'(i * 4);
            end
        end else begin
            apb_prev_setup  <= o_apb_psel && !o_apb_penable;
            apb_prev_enable <= o_apb_penable;
            i_apb_pready    <= 1'b0;
            if (o_apb_psel && !o_apb_penable) begin
                check_value("o_apb_paddr", 64'(o_apb_paddr), 64'(exp_paddr));
                check_value("o_apb_pwrite", 64'(o_apb_pwrite), 64'(exp_pwrite));
                if (o_apb_pwrite) begin
                    check_value("o_apb_pwdata", 64'(o_apb_pwdata), 64'(exp_pwdata));
                end
                apb_wait <= int'($urandom % 4);
            end else if (o_apb_penable) begin
                check_value("o_apb_psel", 64'(o_apb_psel), 64'(1'b1));
                if (!apb_prev_enable) begin
                    check_value("setup before o_apb_penable", 64'(apb_prev_setup), 64'(1'b1));
                end
                if (i_apb_pready) begin
                    // Transfer ends on this edge
                    if (o_apb_pwrite) begin
                        apb_regs[o_apb_paddr[5:2]] <= o_apb_pwdata;
                    end
                end else if (apb_wait == 0) begin
                    i_apb_pready <= 1'b1;
                    i_apb_prdata <= apb_regs[o_apb_paddr[5:2]];
                end else begin
                    apb_wait <= apb_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (i_rst) begin
            i_mem_ack  <= 1'b0;
            mem_active <= 1'b0;
        end else begin
            i_mem_ack <= 1'b0;
            if (o_mem_req && !i_mem_ack && !mem_never_ack) begin
                if (!mem_active) begin
                    mem_active <= 1'b1;
                    mem_wait   <= int'($urandom % 5);
                end else if (mem_wait == 0) begin
                    check_value("o_mem_wr", 64'(o_mem_wr), 64'(exp_mem_wr));
                    i_mem_ack   <= 1'b1;
                    i_mem_rdata <= mem_read(o_mem_addr);
                    mem_active  <= 1'b0;
                    if (o_mem_wr) begin
                        mem_model[o_mem_addr] = o_mem_wdata;
                    end
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end
        end
    end

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        logic [REG_DATA_WID-1:0] rdata;
        @(negedge clk);
        check_value("o_apb_psel", 64'(o_apb_psel), 64'(1'b0));
        check_value("o_mem_req", 64'(o_mem_req), 64'(1'b0));
        check_value("o_init_done", 64'(o_init_done), 64'(1'b0));
        reg_read(REG_CONTROL, rdata);
        check_value("REG_CONTROL", 64'(rdata), 64'(32'h0));
        reg_read(REG_STATUS, rdata);
        check_value("REG_STATUS[0]", 64'(rdata[0]), 64'(1'b0));
        reg_read(REG_MEM_STATUS, rdata);
        check_value("REG_MEM_STATUS", 64'(rdata), 64'(32'h0));
    endtask

    task automatic test_status_sampling();
        logic [6:0]              temp;
        logic                    cattrip;
        logic [REG_DATA_WID-1:0] expected;
        logic [REG_DATA_WID-1:0] rdata;
        int                      polls;
        temp     = 7'($urandom % 127) + 7'd1;
        cattrip  = 1'($urandom);
        expected = {23'd0, cattrip, 1'b0, temp};
        polls    = 0;
        @(posedge clk);
        i_dram_temp    <= temp;
        i_dram_cattrip <= cattrip;
        i_apb_complete <= 1'b1;
        reg_read(REG_DRAM_STATUS, rdata);
        while (rdata !== expected) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_run("DRAM status never showed the driven inputs");
            end
            reg_read(REG_DRAM_STATUS, rdata);
        end
        @(negedge clk);
        check_value("o_init_done", 64'(o_init_done), 64'(1'b1));
        reg_read(REG_STATUS, rdata);
        check_value("REG_STATUS[1]", 64'(rdata[1]), 64'(1'b1));
    endtask

    task automatic test_apb_forwarding();
        logic [REG_DATA_WID-1:0] shadow [APB_DEPTH];
        int                      idx [6];
        logic [REG_DATA_WID-1:0] data;
        logic [REG_DATA_WID-1:0] rdata;
        for (int k = 0; k < 6; k++) begin
            idx[k]     = int'($urandom % APB_DEPTH);
            data       = $urandom;
            exp_paddr  = APB_ADDR_WID'(idx[k] * 4);
            exp_pwrite = 1'b1;
            exp_pwdata = data;
            reg_write({REGION_APB, exp_paddr}, data);
            shadow[idx[k]] = data;
        end
        for (int k = 0; k < 6; k++) begin
            exp_paddr  = APB_ADDR_WID'(idx[k] * 4);
            exp_pwrite = 1'b0;
            reg_read({REGION_APB, exp_paddr}, rdata);
            check_value("APB read data", 64'(rdata), 64'(shadow[idx[k]]));
            check_value("APB model array", 64'(apb_regs[idx[k]]), 64'(shadow[idx[k]]));
        end
    endtask

    task automatic test_mem_write_read();
        logic [MEM_ADDR_WID-1:0] addr;
        logic [MEM_DATA_WID-1:0] data;
        logic [REG_DATA_WID-1:0] status;
        logic [REG_DATA_WID-1:0] rdata;
        addr = 24'($urandom);
        data = {$urandom, $urandom};
        reg_write(REG_MEM_ADDR, 32'(addr));
        reg_write(REG_MEM_WDATA_LO, data[31:0]);
        reg_write(REG_MEM_WDATA_HI, data[63:32]);
        exp_mem_wr = 1'b1;
        reg_write(REG_MEM_COMMAND, 32'(CMD_WRITE));
        wait_mem_idle(status);
        check_value("REG_MEM_STATUS after write", 64'(status[2:0]), 64'(3'b010));
        check_value("memory model data", mem_read(addr), data);
        exp_mem_wr = 1'b0;
        reg_write(REG_MEM_COMMAND, 32'(CMD_READ));
        wait_mem_idle(status);
        check_value("REG_MEM_STATUS after read", 64'(status[2:0]), 64'(3'b010));
        reg_read(REG_MEM_RDATA_LO, rdata);
        check_value("REG_MEM_RDATA_LO", 64'(rdata), 64'(data[31:0]));
        reg_read(REG_MEM_RDATA_HI, rdata);
        check_value("REG_MEM_RDATA_HI", 64'(rdata), 64'(data[63:32]));
    endtask

    task automatic test_timeout_soft_reset();
        logic [REG_DATA_WID-1:0] status;
        logic [REG_DATA_WID-1:0] rdata;
        mem_never_ack = 1'b1;
        reg_write(REG_MEM_COMMAND, 32'(CMD_READ));
        wait_mem_idle(status);
        check_value("REG_MEM_STATUS after timeout", 64'(status[2:0]), 64'(3'b100));
        @(negedge clk);
        check_value("o_mem_req", 64'(o_mem_req), 64'(1'b0));
        mem_never_ack = 1'b0;
        reg_write(REG_CONTROL, 32'h1);
        reg_read(REG_STATUS, rdata);
        check_value("REG_STATUS[0]", 64'(rdata[0]), 64'(1'b1));
        reg_read(REG_MEM_STATUS, rdata);
        check_value("REG_MEM_STATUS in soft reset", 64'(rdata), 64'(32'h0));
        reg_write(REG_CONTROL, 32'h0);
        reg_read(REG_STATUS, rdata);
        check_value("REG_STATUS[0]", 64'(rdata[0]), 64'(1'b0));
    endtask

    task automatic test_unmapped();
        logic [REG_DATA_WID-1:0] rdata;
        reg_read({REGION_NONE, 10'h000}, rdata);
        check_value("unmapped read", 64'(rdata), 64'(UNMAPPED_RDATA));
        // Ack is the only response to a dropped write
        reg_write({REGION_NONE, 10'h000}, $urandom);
        reg_read({REGION_NONE, 10'h000}, rdata);
        check_value("unmapped read after write", 64'(rdata), 64'(UNMAPPED_RDATA));
    endtask

    initial begin
        void'($urandom(32'h7617_86b3));
        mem_never_ack  = 1'b0;
        exp_mem_wr     = 1'b0;
        exp_paddr      = '0;
        exp_pwrite     = 1'b0;
        exp_pwdata     = '0;
        i_rst          <= 1'b1;
        i_reg_req      <= 1'b0;
        i_reg_wr       <= 1'b0;
        i_reg_addr     <= '0;
        i_reg_wdata    <= '0;
        i_apb_complete <= 1'b0;
        i_dram_cattrip <= 1'b0;
        i_dram_temp    <= '0;
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;

        test_reset_state();
        test_status_sampling();
        test_apb_forwarding();
        test_mem_write_read();
        test_timeout_soft_reset();
        test_unmapped();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* compile.f */
hbm_ctrl_pkg.sv
reg_bus_if.sv
hbm_reg_decoder.sv
hbm_stack_regs.sv
hbm_apb_bridge.sv
hbm_mem_proxy.sv
hbm_stack_ctrl.sv
tb_clock_gen.sv
tb_hbm_stack_ctrl.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_hbm_stack_ctrl
RTL_TOP     ?= hbm_stack_ctrl
FILELIST    ?= compile.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing
BUILD_FLAGS ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
